//--- source/rob_defs.svh
// sizing macros for the two-thread reorder buffer
// queue depth, register file sizes, pc width and the idle register number

`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// entries per thread queue, must stay a power of two
`define ROB_SIZE	8
`define ROB_IDX_W	($clog2(`ROB_SIZE))

`define PRF_SIZE	64
`define PRN_W		($clog2(`PRF_SIZE))

`define ARN_W		5
`define PC_W		64
`define ZERO_REG	5'd31		// shown on an idle commit slot

`endif

//--- source/rob_pkg.sv
// shared types of the reorder buffer
// thread select, queue tag, dispatched instruction, fu completion,
// queue head entry and commit slot

`include "rob_defs.svh"

package rob_pkg;

	typedef enum logic {
		thread_1 = 1'b0,
		thread_2 = 1'b1
	} thread_e;

	typedef struct packed {
		thread_e				thread;
		logic [`ROB_IDX_W-1:0]	idx;		// slot inside the thread queue
	} rob_tag_t;

	typedef struct packed {
		logic [`PC_W-1:0]		pc;
		logic [`ARN_W-1:0]		arn;		// architectural destination
		logic [`PRN_W-1:0]		prn;		// physical destination
		logic					is_branch;
		logic					is_uncond_branch;
		logic					is_halt;
	} dispatch_inst_t;

	typedef struct packed {
		logic					valid;
		rob_tag_t				tag;
		logic					mispredict;
		logic [`PC_W-1:0]		target_pc;
	} fu_done_t;

	// ready means occupied and executed
	typedef struct packed {
		logic					ready;
		dispatch_inst_t			inst;
		logic					mispredict;
		logic [`PC_W-1:0]		target_pc;
	} head_entry_t;

	typedef struct packed {
		logic					valid;
		thread_e				thread;
		dispatch_inst_t			inst;
		logic [`PC_W-1:0]		target_pc;
		logic					mispredict;	// already masked on unconditional branches
	} commit_t;

endpackage

//--- source/rob_dispatch.sv
// dispatch steering for the reorder buffer
// decodes the load strobes and thread select into bank write strobes
// and forms the queue tags returned to the reservation stations

`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_dispatch import rob_pkg::*;
(
	input	thread_e						thread_sel,
	input	logic							inst1_load,
	input	logic							inst2_load,
	input	logic [`ROB_IDX_W-1:0]			t1_tail,
	input	logic [`ROB_IDX_W-1:0]			t2_tail,
	output	logic							t1_wr1,
	output	logic							t1_wr2,
	output	logic							t2_wr1,
	output	logic							t2_wr2,
	output	rob_tag_t						tag1,
	output	rob_tag_t						tag2
);

	localparam int IDX_W = `ROB_IDX_W;

	logic [IDX_W-1:0]	sel_tail;
	logic				dual;		// both instructions go in this cycle
	logic				to_t1;

	assign to_t1 = (thread_sel == thread_1);
	assign sel_tail = to_t1 ? t1_tail : t2_tail;

	// inst2 alone is ignored, it only rides along with inst1
	assign dual = inst1_load && inst2_load;

	assign t1_wr1 = inst1_load && to_t1;
	assign t1_wr2 = dual && to_t1;
	assign t2_wr1 = inst1_load && !to_t1;
	assign t2_wr2 = dual && !to_t1;

	always_comb
	begin
		tag1 = '0;
		tag2 = '0;
		if (inst1_load)
		begin
			tag1.thread = thread_sel;
			tag1.idx = sel_tail;
		end
		if (dual)
		begin
			tag2.thread = thread_sel;
			tag2.idx = sel_tail + IDX_W'(1);	// second slot wraps with the ring
		end
	end

endmodule

//--- source/rob_bank.sv
// one thread queue of the reorder buffer
// circular entry store with head, tail and occupancy count,
// completion marking for its own thread, retire, flush and full flag

`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_bank import rob_pkg::*;
#(
	parameter thread_e THREAD = thread_1
)
(
	input	logic						clock,
	input	logic						reset,
	input	dispatch_inst_t				inst1,
	input	dispatch_inst_t				inst2,
	input	logic						wr1,
	input	logic						wr2,
	input	fu_done_t					fu1,
	input	fu_done_t					fu2,
	input	logic [1:0]					retire,
	input	logic						flush,
	output	logic [`ROB_IDX_W-1:0]		tail,
	output	head_entry_t				head0,
	output	head_entry_t				head1,
	output	logic						full
);

	localparam int IDX_W = `ROB_IDX_W;
	localparam int CNT_W = `ROB_IDX_W + 1;

	dispatch_inst_t		inst_q [`ROB_SIZE];
	logic [`PC_W-1:0]	target_q [`ROB_SIZE];
	logic				mispredict_q [`ROB_SIZE];

	logic [`ROB_SIZE-1:0]	occupied;
	logic [`ROB_SIZE-1:0]	executed;
	logic [IDX_W-1:0]		head;
	logic [IDX_W-1:0]		head_p1;
	logic [IDX_W-1:0]		head_next;
	logic [IDX_W-1:0]		tail_p1;
	logic [CNT_W-1:0]		count;		// occupied entries
	logic [1:0]				wr_count;
	logic					fu1_hit;
	logic					fu2_hit;

	assign head_p1 = head + IDX_W'(1);
	assign head_next = head + IDX_W'(retire);
	assign tail_p1 = tail + IDX_W'(1);
	assign wr_count = {1'b0, wr1} + {1'b0, wr2};

	// completions to empty or flushed slots fall through here
	assign fu1_hit = fu1.valid && (fu1.tag.thread == THREAD) && occupied[fu1.tag.idx];
	assign fu2_hit = fu2.valid && (fu2.tag.thread == THREAD) && occupied[fu2.tag.idx];

	// entry payload
	always_ff @(posedge clock)
	begin
		if (fu1_hit)
		begin
			mispredict_q[fu1.tag.idx] <= fu1.mispredict;
			target_q[fu1.tag.idx] <= fu1.target_pc;
		end
		if (fu2_hit)
		begin
			mispredict_q[fu2.tag.idx] <= fu2.mispredict;
			target_q[fu2.tag.idx] <= fu2.target_pc;
		end
		if (wr1 && !flush)
			inst_q[tail] <= inst1;
		if (wr2 && !flush)
			inst_q[tail_p1] <= inst2;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			occupied <= '0;
			executed <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			head <= head_next;
			if (flush)
			begin
				// younger entries are dropped, along with any dispatch this cycle
				occupied <= '0;
				executed <= '0;
				tail <= head_next;
				count <= '0;
			end
			else
			begin
				if (retire != 2'd0)
				begin
					occupied[head] <= 1'b0;
					executed[head] <= 1'b0;
				end
				if (retire == 2'd2)
				begin
					occupied[head_p1] <= 1'b0;
					executed[head_p1] <= 1'b0;
				end
				if (fu1_hit)
					executed[fu1.tag.idx] <= 1'b1;
				if (fu2_hit)
					executed[fu2.tag.idx] <= 1'b1;
				if (wr1)
				begin
					occupied[tail] <= 1'b1;
					executed[tail] <= 1'b0;
				end
				if (wr2)
				begin
					occupied[tail_p1] <= 1'b1;
					executed[tail_p1] <= 1'b0;
				end
				tail <= tail + IDX_W'(wr_count);
				count <= count + CNT_W'(wr_count) - CNT_W'(retire);
			end
		end
	end

	// two oldest entries toward commit
	assign head0 = {occupied[head] && executed[head], inst_q[head],
		mispredict_q[head], target_q[head]};
	assign head1 = {occupied[head_p1] && executed[head_p1], inst_q[head_p1],
		mispredict_q[head_p1], target_q[head_p1]};

	assign full = (count >= CNT_W'(`ROB_SIZE - 1));	// fewer than two free

endmodule

//--- source/rob_commit.sv
// commit selection for the reorder buffer
// fills two commit slots from the thread heads in program order,
// masks mispredict on unconditional branches and derives
// per-thread retire counts and flushes

`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_commit import rob_pkg::*;
(
	input	head_entry_t		t1_head0,
	input	head_entry_t		t1_head1,
	input	head_entry_t		t2_head0,
	input	head_entry_t		t2_head1,
	output	commit_t			commit1,
	output	commit_t			commit2,
	output	logic [1:0]			t1_retire,
	output	logic [1:0]			t2_retire,
	output	logic				t1_flush,
	output	logic				t2_flush
);

	function automatic commit_t idle_slot();
		commit_t c;
		c = '0;
		c.inst.arn = `ZERO_REG;
		return c;
	endfunction

	function automatic commit_t make_commit(input head_entry_t entry, input thread_e thread);
		commit_t c;
		c.valid = 1'b1;
		c.thread = thread;
		c.inst = entry.inst;
		c.target_pc = entry.target_pc;
		c.mispredict = entry.mispredict && !entry.inst.is_uncond_branch;
		return c;
	endfunction

	// mispredicted conditional branch, the mispredict is already masked
	function automatic logic redirects(input commit_t c);
		return c.valid && c.inst.is_branch && c.mispredict;
	endfunction

	// no second commit of the same thread after a halt or a redirect
	function automatic logic blocks_next(input commit_t c);
		return c.inst.is_halt || redirects(c);
	endfunction

	always_comb
	begin
		commit1 = idle_slot();
		commit2 = idle_slot();
		t1_retire = 2'd0;
		t2_retire = 2'd0;
		if (t1_head0.ready)
		begin
			commit1 = make_commit(t1_head0, thread_1);
			t1_retire = 2'd1;
			if (t1_head1.ready && !blocks_next(commit1))
			begin
				commit2 = make_commit(t1_head1, thread_1);
				t1_retire = 2'd2;
			end
			else if (t2_head0.ready)
			begin
				commit2 = make_commit(t2_head0, thread_2);	// other thread fills slot 2
				t2_retire = 2'd1;
			end
		end
		else if (t2_head0.ready)
		begin
			commit1 = make_commit(t2_head0, thread_2);
			t2_retire = 2'd1;
			if (t2_head1.ready && !blocks_next(commit1))
			begin
				commit2 = make_commit(t2_head1, thread_2);
				t2_retire = 2'd2;
			end
		end
	end

	// a redirect in either slot flushes its own thread
	assign t1_flush = (redirects(commit1) && commit1.thread == thread_1)
		|| (redirects(commit2) && commit2.thread == thread_1);
	assign t2_flush = (redirects(commit1) && commit1.thread == thread_2)
		|| (redirects(commit2) && commit2.thread == thread_2);

endmodule

//--- source/smt_rob.sv
// two-thread reorder buffer top level
// dispatch steering, one queue per thread and the commit selector

`timescale 1ns/10ps
`include "rob_defs.svh"

module smt_rob import rob_pkg::*;
(
	input	logic				clock,
	input	logic				reset,
	input	thread_e			thread_sel,
	input	dispatch_inst_t		inst1,
	input	dispatch_inst_t		inst2,
	input	logic				inst1_load,
	input	logic				inst2_load,
	input	fu_done_t			fu1,
	input	fu_done_t			fu2,
	output	rob_tag_t			tag1,
	output	rob_tag_t			tag2,
	output	commit_t			commit1,
	output	commit_t			commit2,
	output	logic				t1_full,
	output	logic				t2_full
);

	logic [`ROB_IDX_W-1:0]	t1_tail;
	logic [`ROB_IDX_W-1:0]	t2_tail;
	logic					t1_wr1;
	logic					t1_wr2;
	logic					t2_wr1;
	logic					t2_wr2;
	head_entry_t			t1_head0;
	head_entry_t			t1_head1;
	head_entry_t			t2_head0;
	head_entry_t			t2_head1;
	logic [1:0]				t1_retire;
	logic [1:0]				t2_retire;
	logic					t1_flush;
	logic					t2_flush;

	rob_dispatch u_dispatch (
		.thread_sel(thread_sel), .inst1_load(inst1_load), .inst2_load(inst2_load),
		.t1_tail(t1_tail), .t2_tail(t2_tail),
		.t1_wr1(t1_wr1), .t1_wr2(t1_wr2), .t2_wr1(t2_wr1), .t2_wr2(t2_wr2),
		.tag1(tag1), .tag2(tag2)
	);

	rob_bank #(.THREAD(thread_1)) u_bank_t1 (
		.clock(clock), .reset(reset), .inst1(inst1), .inst2(inst2),
		.wr1(t1_wr1), .wr2(t1_wr2), .fu1(fu1), .fu2(fu2),
		.retire(t1_retire), .flush(t1_flush), .tail(t1_tail),
		.head0(t1_head0), .head1(t1_head1), .full(t1_full)
	);

	rob_bank #(.THREAD(thread_2)) u_bank_t2 (
		.clock(clock), .reset(reset), .inst1(inst1), .inst2(inst2),
		.wr1(t2_wr1), .wr2(t2_wr2), .fu1(fu1), .fu2(fu2),
		.retire(t2_retire), .flush(t2_flush), .tail(t2_tail),
		.head0(t2_head0), .head1(t2_head1), .full(t2_full)
	);

	rob_commit u_commit (
		.t1_head0(t1_head0), .t1_head1(t1_head1),
		.t2_head0(t2_head0), .t2_head1(t2_head1),
		.commit1(commit1), .commit2(commit2),
		.t1_retire(t1_retire), .t2_retire(t2_retire),
		.t1_flush(t1_flush), .t2_flush(t2_flush)
	);

endmodule

//--- testbench/tb_clock.sv
// clock and reset source for the reorder buffer testbench
// 4 ns clock period, reset held high for the first 8 cycles

`timescale 1ns/10ps

module tb_clock
(
	output	logic	clock,
	output	logic	reset
);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (8) @(posedge clock);
		@(negedge clock);		// release away from the active edge
		reset = 1'b0;
	end

endmodule

//--- testbench/smt_rob_tb.sv
// testbench for the two-thread reorder buffer
// table of dispatch and completion stimulus with expected tags, commits
// and full flags, one row per clock, the compare task and the verdict

`timescale 1ns/10ps
`include "rob_defs.svh"

module smt_rob_tb import rob_pkg::*;
();

	localparam logic [2:0] PLAIN = 3'b000;	// kind {branch, uncond, halt}
	localparam logic [2:0] BR = 3'b100;
	localparam logic [2:0] JMP = 3'b110;
	localparam logic [2:0] HALT = 3'b001;
	localparam logic [1:0] DUAL = 2'b11;
	localparam logic [1:0] ONE = 2'b10;
	localparam logic [1:0] NONE = 2'b00;
	localparam logic [5:0] NO_FU = 6'b0;	// fu {valid, thread, idx, mispredict}
	localparam logic [7:0] IDLE = 8'h00;	// commit {valid, thread, mispredict, pc slot}

	typedef struct packed {
		thread_e		sel;
		logic [1:0]		ld;			// {inst1_load, inst2_load}
		logic [4:0]		p1;			// pc slots
		logic [4:0]		p2;
		logic [2:0]		k1;
		logic [2:0]		k2;
		logic [5:0]		fu1;
		logic [5:0]		fu2;
		logic [7:0]		tags;		// {tag1, tag2}
		logic [7:0]		c1;
		logic [7:0]		c2;
		logic [1:0]		full;		// {t2_full, t1_full}
	} row_t;

	logic				clock;
	logic				reset;
	thread_e			thread_sel;
	dispatch_inst_t		inst1;
	dispatch_inst_t		inst2;
	logic				inst1_load;
	logic				inst2_load;
	fu_done_t			fu1;
	fu_done_t			fu2;
	rob_tag_t			tag1;
	rob_tag_t			tag2;
	commit_t			commit1;
	commit_t			commit2;
	logic				t1_full;
	logic				t2_full;

	logic [`PC_W-1:0]	pcs [32];
	row_t				rows [$];
	logic [7:0]			tags_seen;
	integer				seed = 37;
	int					errors = 0;
	int					timeouts = 0;
	int					r;

	tb_clock u_clock (.clock(clock), .reset(reset));

	smt_rob dut (.*);

	task automatic compare(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("** Error row %0d %s: expected %h, got %h", r, name, expected, actual);
		end
	endtask

	// idle commit slots show a zero pc
	function automatic logic [63:0] expected_pc(input logic [7:0] c);
		return c[7] ? pcs[c[4:0]] : 64'd0;
	endfunction

	// arn of a dispatched instruction is its pc slot, idle slots show ZERO_REG
	function automatic logic [63:0] expected_arn(input logic [7:0] c);
		return c[7] ? 64'(c[4:0]) : 64'(`ZERO_REG);
	endfunction

	// every completion in the table carries the shared target pc
	function automatic logic [63:0] expected_target(input logic [7:0] c);
		return c[7] ? pcs[31] : 64'd0;
	endfunction

	task automatic drive_row(input row_t row);
		thread_sel = row.sel;
		inst1_load = row.ld[1];
		inst2_load = row.ld[0];
		inst1 = {pcs[row.p1], row.p1, {1'b0, row.p1}, row.k1};
		inst2 = {pcs[row.p2], row.p2, {1'b0, row.p2}, row.k2};
		fu1 = {row.fu1[5:1], row.fu1[0], pcs[31]};		// one shared target pc
		fu2 = {row.fu2[5:1], row.fu2[0], pcs[31]};
	endtask

	task automatic check_row(input row_t row);
		compare("tag1", 64'(row.tags[7:4]), 64'(tags_seen[7:4]));
		compare("tag2", 64'(row.tags[3:0]), 64'(tags_seen[3:0]));
		compare("commit1.valid", 64'(row.c1[7]), 64'(commit1.valid));
		compare("commit1.thread", 64'(row.c1[6]), 64'(commit1.thread));
		compare("commit1.pc", expected_pc(row.c1), commit1.inst.pc);
		compare("commit1.arn", expected_arn(row.c1), 64'(commit1.inst.arn));
		compare("commit1.target_pc", expected_target(row.c1), commit1.target_pc);
		compare("commit1.mispredict", 64'(row.c1[5]), 64'(commit1.mispredict));
		compare("commit2.valid", 64'(row.c2[7]), 64'(commit2.valid));
		compare("commit2.thread", 64'(row.c2[6]), 64'(commit2.thread));
		compare("commit2.pc", expected_pc(row.c2), commit2.inst.pc);
		compare("commit2.arn", expected_arn(row.c2), 64'(commit2.inst.arn));
		compare("commit2.target_pc", expected_target(row.c2), commit2.target_pc);
		compare("commit2.mispredict", 64'(row.c2[5]), 64'(commit2.mispredict));
		compare("t1_full", 64'(row.full[0]), 64'(t1_full));
		compare("t2_full", 64'(row.full[1]), 64'(t2_full));
	endtask

	// reset release, then idle commit ports and low full flags
	task automatic wait_quiet();
		int cycles;
		logic quiet;
		cycles = 0;
		quiet = 1'b0;
		while (!quiet && cycles < 40)
		begin
			@(negedge clock);
			#1;
			cycles++;
			quiet = (reset === 1'b0) && (commit1.valid === 1'b0)
				&& (commit2.valid === 1'b0) && (t1_full === 1'b0) && (t2_full === 1'b0);
		end
		if (!quiet)
		begin
			timeouts++;
			$display("timeout: the DUT never came out of reset with idle outputs");
		end
	endtask

	initial
	begin
		thread_sel = thread_1;
		inst1 = '0;
		inst2 = '0;
		inst1_load = 1'b0;
		inst2_load = 1'b0;
		fu1 = '0;
		fu2 = '0;
		for (int i = 0; i < 32; i++)
			pcs[i] = {$random(seed), $random(seed)};

		// in-order pair, older completes last, then cross-thread fill of slot 2
		rows.push_back({thread_1, DUAL, 5'd0, 5'd1, PLAIN, PLAIN, NO_FU, NO_FU, 8'h01,
			IDLE, IDLE, 2'b00});
		rows.push_back({thread_1, NONE, 5'd0, 5'd0, PLAIN, PLAIN, 6'b10_001_0, NO_FU, 8'h00,
			IDLE, IDLE, 2'b00});
		rows.push_back({thread_1, NONE, 5'd0, 5'd0, PLAIN, PLAIN, 6'b10_000_0, NO_FU, 8'h00,
			8'h80, 8'h81, 2'b00});
		rows.push_back({thread_2, DUAL, 5'd2, 5'd3, PLAIN, PLAIN, NO_FU, NO_FU, 8'h89,
			IDLE, IDLE, 2'b00});
		rows.push_back({thread_1, DUAL, 5'd4, 5'd5, PLAIN, PLAIN, 6'b11_000_0, NO_FU, 8'h23,
			8'hC2, IDLE, 2'b00});
		rows.push_back({thread_1, NONE, 5'd0, 5'd0, PLAIN, PLAIN, 6'b10_010_0, 6'b11_001_0,
			8'h00, 8'h84, 8'hC3, 2'b00});
		// mispredicted branch flushes thread 1 and the completion of its follower is dropped
		rows.push_back({thread_1, DUAL, 5'd6, 5'd7, BR, PLAIN, 6'b10_011_0, NO_FU, 8'h45,
			8'h85, IDLE, 2'b00});
		rows.push_back({thread_1, NONE, 5'd0, 5'd0, PLAIN, PLAIN, 6'b10_100_1, NO_FU, 8'h00,
			8'hA6, IDLE, 2'b00});
		rows.push_back({thread_1, NONE, 5'd0, 5'd0, PLAIN, PLAIN, 6'b10_101_0, NO_FU, 8'h00,
			IDLE, IDLE, 2'b00});
		rows.push_back({thread_1, DUAL, 5'd8, 5'd9, JMP, PLAIN, 6'b10_101_0, NO_FU, 8'h56,
			IDLE, IDLE, 2'b00});
		rows.push_back({thread_1, NONE, 5'd0, 5'd0, PLAIN, PLAIN, 6'b10_101_1, 6'b10_110_0,
			8'h00, 8'h88, 8'h89, 2'b00});
		// halt holds back its own thread for one cycle
		rows.push_back({thread_2, DUAL, 5'd10, 5'd11, HALT, PLAIN, NO_FU, NO_FU, 8'hAB,
			IDLE, IDLE, 2'b00});
		rows.push_back({thread_2, NONE, 5'd0, 5'd0, PLAIN, PLAIN, 6'b11_010_0, 6'b11_011_0,
			8'h00, 8'hCA, IDLE, 2'b00});
		rows.push_back({thread_2, NONE, 5'd0, 5'd0, PLAIN, PLAIN, NO_FU, NO_FU, 8'h00,
			8'hCB, IDLE, 2'b00});
		// fill thread 2 until fewer than two entries are free
		rows.push_back({thread_2, DUAL, 5'd12, 5'd13, PLAIN, PLAIN, NO_FU, NO_FU, 8'hCD,
			IDLE, IDLE, 2'b00});
		rows.push_back({thread_2, DUAL, 5'd14, 5'd15, PLAIN, PLAIN, NO_FU, NO_FU, 8'hEF,
			IDLE, IDLE, 2'b00});
		rows.push_back({thread_2, DUAL, 5'd16, 5'd17, PLAIN, PLAIN, NO_FU, NO_FU, 8'h89,
			IDLE, IDLE, 2'b00});
		rows.push_back({thread_2, ONE, 5'd18, 5'd0, PLAIN, PLAIN, NO_FU, NO_FU, 8'hA0,
			IDLE, IDLE, 2'b10});

		wait_quiet();
		if (timeouts == 0)
		begin
			for (r = 0; r < rows.size(); r++)
			begin
				@(negedge clock);
				drive_row(rows[r]);
				#1;
				tags_seen = {tag1, tag2};	// tags belong to the cycle before the write edge
				#2.5;
				check_row(rows[r]);
			end
		end

		$display("mismatches: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- smt_rob.f
+incdir+source
source/rob_pkg.sv
source/rob_dispatch.sv
source/rob_bank.sv
source/rob_commit.sv
source/smt_rob.sv
testbench/tb_clock.sv
testbench/smt_rob_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/10ps -f smt_rob.f --top-module smt_rob_tb
	./obj_dir/Vsmt_rob_tb | tee /dev/stderr | grep "^=== PASS ===$$" > /dev/null

clean:
	rm -rf obj_dir
